/* design/cam_view_defines.svh */
`ifndef CAM_VIEW_DEFINES_SVH
`define CAM_VIEW_DEFINES_SVH

// xga 1024x768 at 60 hz, one pixel per clk_65mhz cycle
`define H_ACTIVE 1024
`define H_FRONT 24
`define H_SYNC 136
`define H_BACK 160
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)  // 1344 cycles per line

`define V_ACTIVE 768
`define V_FRONT 3
`define V_SYNC 6
`define V_BACK 29
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)  // 806 lines per frame

// qvga camera image
`define IMG_W 320
`define IMG_H 240

// where the gray window sits on screen
`define WIN_X0 64
`define WIN_Y0 64

`define FB_DEPTH (`IMG_W * `IMG_H)  // one gray word per pixel

// camera clock and pin synchronizer
`define XCLK_DIV 4
`define SYNC_STAGES 2

`endif

/* design/camera_pkg.sv */
package camera_pkg;

  // rgb565 as it comes off the camera
  // red [15:11], green [10:5], blue [4:0]
  typedef logic [15:0] pix565_t;

  typedef logic [7:0] luma_t;  // gray level

  typedef logic [16:0] fb_addr_t;  // covers 76800 words

  // byte pairing states of the capture fsm
  typedef enum logic [1:0] {
    wait_frame,  // no vsync seen yet
    high_byte,   // next pclk edge carries the high byte
    low_byte     // next pclk edge completes the pixel
  } cap_state_t;

endpackage

/* design/video_pkg.sv */
package video_pkg;

  // screen position, 1344 wide total
  typedef logic [10:0] hcount_t;

  // line number, 806 lines total
  typedef logic [9:0] vcount_t;

  // one vga color channel, 4 bit dac
  typedef logic [3:0] vga_chan_t;

endpackage

/* design/cam_pixel_if.sv */
`timescale 1ns/1ns

interface cam_pixel_if;
  import camera_pkg::*;

  pix565_t  pixel;        // valid with pixel_valid
  logic     pixel_valid;  // one cycle per pixel
  logic     frame_start;  // one cycle on camera vsync rise
  fb_addr_t addr;         // arrival order from 0

  modport source (
    output pixel, pixel_valid, frame_start, addr
  );

  // no back-pressure, every pulse is taken
  modport sink (
    input pixel, pixel_valid, frame_start, addr
  );

endinterface

/* design/video_timing_if.sv */
`timescale 1ns/1ns

interface video_timing_if;
  import video_pkg::*;

  hcount_t hcount;  // pixel in line
  vcount_t vcount;  // line in frame
  logic    hsync;   // active high here
  logic    vsync;   // active high here
  logic    blank;   // outside 1024x768

  modport source (
    output hcount, vcount, hsync, vsync, blank
  );

  modport sink (
    input hcount, vcount, hsync, vsync, blank
  );

endinterface

/* design/cam_capture.sv */
`timescale 1ns/1ns
`include "cam_view_defines.svh"

module cam_capture (
  input  logic        clk_65mhz,
  input  logic        reset,
  input  logic [7:0]  cam_data,
  input  logic        cam_pclk,
  input  logic        cam_vsync,
  input  logic        cam_href,
  output logic        cam_xclk,
  cam_pixel_if.source pix
);
  import camera_pkg::*;

  logic [10:0] sync_q [`SYNC_STAGES];  // {pclk, vsync, href, data}
  logic [10:0] pins_s;                 // last sync stage
  logic        pclk_q, vsync_q;        // edge detect
  logic        pclk_rise, vsync_rise;
  cap_state_t  state;
  logic [7:0]  high_byte_q;            // first half of the pixel
  fb_addr_t    next_addr;
  logic [7:0]  xclk_cnt;

  assign pins_s = sync_q[`SYNC_STAGES-1];
  assign pclk_rise = pins_s[10] & ~pclk_q;
  assign vsync_rise = pins_s[9] & ~vsync_q;

  // camera pins are async to clk_65mhz
  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      for (int i = 0; i < `SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
      pclk_q <= 1'b0;
      vsync_q <= 1'b0;
    end else begin
      sync_q[0] <= {cam_pclk, cam_vsync, cam_href, cam_data};
      for (int i = 1; i < `SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      pclk_q <= pins_s[10];
      vsync_q <= pins_s[9];
    end
  end

  // byte pairing fsm
  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      state <= wait_frame;
      next_addr <= '0;
      pix.pixel_valid <= 1'b0;
      pix.frame_start <= 1'b0;
    end else begin
      pix.pixel_valid <= 1'b0;  // strobes default low
      pix.frame_start <= 1'b0;
      if (vsync_rise) begin
        state <= high_byte;  // new frame restarts pairing
        next_addr <= '0;
        pix.frame_start <= 1'b1;
      end else if (pclk_rise && state != wait_frame) begin
        if (!pins_s[8]) begin
          state <= high_byte;  // href low, between lines
        end else if (state == high_byte) begin
          state <= low_byte;
        end else begin
          state <= high_byte;
          // extra pixels past the buffer are dropped
          if (next_addr < `FB_DEPTH) begin
            pix.pixel_valid <= 1'b1;
            next_addr <= next_addr + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (pclk_rise && state == high_byte) begin
      high_byte_q <= pins_s[7:0];
    end
    if (pclk_rise && state == low_byte) begin
      pix.pixel <= {high_byte_q, pins_s[7:0]};  // high byte first
      pix.addr <= next_addr;
    end
  end

  // camera master clock, div by `XCLK_DIV
  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      xclk_cnt <= '0;
      cam_xclk <= 1'b0;
    end else if (xclk_cnt == `XCLK_DIV/2 - 1) begin
      xclk_cnt <= '0;
      cam_xclk <= ~cam_xclk;
    end else begin
      xclk_cnt <= xclk_cnt + 1'b1;
    end
  end

endmodule

/* design/luma_writer.sv */
`timescale 1ns/1ns
`include "cam_view_defines.svh"

module luma_writer (
  input  logic                 clk_65mhz,
  input  logic                 reset,
  input  logic                 freeze,
  input  camera_pkg::fb_addr_t rd_addr,
  output camera_pkg::luma_t    rd_data,
  cam_pixel_if.sink            pix
);
  import camera_pkg::*;

  luma_t      frame_mem [`FB_DEPTH];  // inferred block ram
  logic [7:0] red8, green8, blue8;
  logic [9:0] luma_sum;               // room above 255
  luma_t      gray;
  luma_t      gray_q;
  fb_addr_t   wr_addr_q;
  logic       wr_en_q;
  logic       armed;                  // first frame_start seen

  // rgb565 to gray with shifts only
  always_comb begin
    red8 = {pix.pixel[15:11], 3'b000};
    green8 = {pix.pixel[10:5], 2'b00};
    blue8 = {pix.pixel[4:0], 3'b000};
    // roughly .30 r + .59 g + .16 b
    luma_sum = (red8 >> 2) + (red8 >> 5) + (red8 >> 6)
             + (green8 >> 1) + (green8 >> 4) + (green8 >> 5)
             + (blue8 >> 3) + (blue8 >> 5);
    gray = (luma_sum > 10'd255) ? 8'd255 : luma_sum[7:0];  // white can hit 258
  end

  // a stream joined mid frame stays out of the buffer
  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      armed <= 1'b0;
      wr_en_q <= 1'b0;
    end else begin
      if (pix.frame_start) begin
        armed <= 1'b1;
      end
      wr_en_q <= pix.pixel_valid & armed & ~freeze;  // freeze holds the image
    end
  end

  always_ff @(posedge clk_65mhz) begin
    gray_q <= gray;
    wr_addr_q <= pix.addr;
  end

  // one write port, one read port, read latency 1
  always_ff @(posedge clk_65mhz) begin
    if (wr_en_q) begin
      frame_mem[wr_addr_q] <= gray_q;
    end
    rd_data <= frame_mem[rd_addr];
  end

endmodule

/* design/vga_timing.sv */
`timescale 1ns/1ns
`include "cam_view_defines.svh"

module vga_timing (
  input  logic           clk_65mhz,
  input  logic           reset,
  video_timing_if.source vt
);
  import video_pkg::*;

  hcount_t h_next;
  vcount_t v_next;

  // next position, wraps at the totals
  always_comb begin
    h_next = vt.hcount + 1'b1;
    v_next = vt.vcount;
    if (vt.hcount == `H_TOTAL - 1) begin
      h_next = '0;
      v_next = (vt.vcount == `V_TOTAL - 1) ? '0 : vt.vcount + 1'b1;
    end
  end

  // decodes use the next count so all outputs line up
  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      vt.hcount <= '0;
      vt.vcount <= '0;
      vt.hsync <= 1'b0;
      vt.vsync <= 1'b0;
      vt.blank <= 1'b0;  // 0,0 is an active pixel
    end else begin
      vt.hcount <= h_next;
      vt.vcount <= v_next;
      // order per line is active, front porch, sync, back porch
      vt.hsync <= (h_next >= `H_ACTIVE + `H_FRONT)
               && (h_next < `H_ACTIVE + `H_FRONT + `H_SYNC);
      vt.vsync <= (v_next >= `V_ACTIVE + `V_FRONT)
               && (v_next < `V_ACTIVE + `V_FRONT + `V_SYNC);
      vt.blank <= (h_next >= `H_ACTIVE) || (v_next >= `V_ACTIVE);
    end
  end

endmodule

/* design/display_window.sv */
`timescale 1ns/1ns
`include "cam_view_defines.svh"

module display_window (
  input  logic                 clk_65mhz,
  input  logic                 reset,
  input  camera_pkg::luma_t    rd_data,
  output camera_pkg::fb_addr_t rd_addr,
  output video_pkg::vga_chan_t vga_r,
  output video_pkg::vga_chan_t vga_g,
  output video_pkg::vga_chan_t vga_b,
  output logic                 vga_hs,
  output logic                 vga_vs,
  video_timing_if.sink         vt
);

  logic       in_win;     // counters inside the gray window
  logic       first_pix;  // top left of the window
  logic [1:0] win_p;      // to the color stage
  logic [1:0] blank_p;
  logic [2:0] hs_p;       // full 3 cycle delay
  logic [2:0] vs_p;

  assign in_win = (vt.hcount >= `WIN_X0) && (vt.hcount < `WIN_X0 + `IMG_W)
               && (vt.vcount >= `WIN_Y0) && (vt.vcount < `WIN_Y0 + `IMG_H);
  assign first_pix = (vt.hcount == `WIN_X0) && (vt.vcount == `WIN_Y0);

  // row major walk, holds between rows
  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      rd_addr <= '0;
    end else if (first_pix) begin
      rd_addr <= '0;
    end else if (in_win) begin
      rd_addr <= rd_addr + 1'b1;
    end
  end

  // stage 1 address, stage 2 ram data, stage 3 pins
  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      win_p <= '0;
      blank_p <= '0;
      hs_p <= '0;
      vs_p <= '0;
    end else begin
      win_p <= {win_p[0], in_win};
      blank_p <= {blank_p[0], vt.blank};
      hs_p <= {hs_p[1:0], vt.hsync};
      vs_p <= {vs_p[1:0], vt.vsync};
    end
  end

  // same gray on all three channels
  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      vga_r <= '0;
      vga_g <= '0;
      vga_b <= '0;
    end else if (win_p[1] && !blank_p[1]) begin
      vga_r <= rd_data[7:4];
      vga_g <= rd_data[7:4];
      vga_b <= rd_data[7:4];
    end else begin
      vga_r <= '0;  // black around the window
      vga_g <= '0;
      vga_b <= '0;
    end
  end

  assign vga_hs = ~hs_p[2];  // active low at the pins
  assign vga_vs = ~vs_p[2];

endmodule

/* design/cam_view_top.sv */
`timescale 1ns/1ns

module cam_view_top (
  input  logic                 clk_65mhz,
  input  logic                 reset,
  input  logic [7:0]           cam_data,
  input  logic                 cam_pclk,
  input  logic                 cam_vsync,
  input  logic                 cam_href,
  input  logic                 freeze,
  output logic                 cam_xclk,
  output video_pkg::vga_chan_t vga_r,
  output video_pkg::vga_chan_t vga_g,
  output video_pkg::vga_chan_t vga_b,
  output logic                 vga_hs,
  output logic                 vga_vs
);
  import camera_pkg::*;

  fb_addr_t rd_addr;  // window readout into frame buffer
  luma_t    rd_data;

  cam_pixel_if    u_pix_if ();  // capture to gray writer
  video_timing_if u_vt_if ();   // timing to window readout

  cam_capture u_cam_capture (
    .clk_65mhz (clk_65mhz),
    .reset     (reset),
    .cam_data  (cam_data),
    .cam_pclk  (cam_pclk),
    .cam_vsync (cam_vsync),
    .cam_href  (cam_href),
    .cam_xclk  (cam_xclk),
    .pix       (u_pix_if.source)
  );

  luma_writer u_luma_writer (
    .clk_65mhz (clk_65mhz),
    .reset     (reset),
    .freeze    (freeze),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .pix       (u_pix_if.sink)
  );

  vga_timing u_vga_timing (
    .clk_65mhz (clk_65mhz),
    .reset     (reset),
    .vt        (u_vt_if.source)
  );

  display_window u_display_window (
    .clk_65mhz (clk_65mhz),
    .reset     (reset),
    .rd_data   (rd_data),
    .rd_addr   (rd_addr),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .vga_hs    (vga_hs),
    .vga_vs    (vga_vs),
    .vt        (u_vt_if.sink)
  );

endmodule

/* sim/cam_view_tb.sv */
`timescale 1ns/1ns
`include "cam_view_defines.svh"

module cam_view_tb;
  import camera_pkg::*;
  import video_pkg::*;

  localparam int FRAME_PIX = 3 * `IMG_W;  // three camera lines per test frame
  localparam int N_ROWS = 12;
  localparam int TIMEOUT_CYCLES = 5 * `H_TOTAL * `V_TOTAL + 2 * FRAME_PIX * 16;

  logic       clk_65mhz;
  logic       reset;
  logic [7:0] cam_data;
  logic       cam_pclk;
  logic       cam_vsync;
  logic       cam_href;
  logic       freeze;
  logic       cam_xclk;
  vga_chan_t  vga_r;
  vga_chan_t  vga_g;
  vga_chan_t  vga_b;
  logic       vga_hs;
  logic       vga_vs;

  // stimulus table, raster order inside each freeze phase
  int          row_x [N_ROWS];
  int          row_y [N_ROWS];
  pix565_t     row_pix [N_ROWS];
  logic        row_frz [N_ROWS];
  luma_t       row_exp [N_ROWS];  // what the screen must show afterwards
  int          n_rows;
  pix565_t     frame_pix [FRAME_PIX];
  logic [31:0] rng_state;

  // screen position recovered from the pins
  int        hs_cnt = -1;    // cycles since vga_hs rose, -1 unknown
  int        line_cnt = -1;  // lines since vga_vs rose
  int        scr_x;
  int        scr_y;
  logic      pos_valid = 1'b0;
  logic      hs_last = 1'b1;
  logic      vs_last = 1'b1;
  logic      hs_fell;
  logic      vs_fell;
  logic      hs_rose;
  logic      vs_rose;
  vga_chan_t blank_or = '0;    // any color seen while blanked
  vga_chan_t outside_or = '0;  // any color seen around the window
  event      sampled;

  int cycle_cnt = 0;
  int test_cnt = 0;
  int fail_cnt = 0;

  cam_view_top u_cam_view_top (
    .clk_65mhz (clk_65mhz),
    .reset     (reset),
    .cam_data  (cam_data),
    .cam_pclk  (cam_pclk),
    .cam_vsync (cam_vsync),
    .cam_href  (cam_href),
    .freeze    (freeze),
    .cam_xclk  (cam_xclk),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .vga_hs    (vga_hs),
    .vga_vs    (vga_vs)
  );

  initial begin
    clk_65mhz = 1'b0;
    forever #10 clk_65mhz = ~clk_65mhz;  // 20 ns period
  end

  always @(posedge clk_65mhz) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout: no result after %0d cycles, the run was stopped", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  // pins are stable at the falling edge
  always @(negedge clk_65mhz) begin
    hs_fell = (hs_last === 1'b1) && (vga_hs === 1'b0);
    vs_fell = (vs_last === 1'b1) && (vga_vs === 1'b0);
    hs_rose = (hs_last === 1'b0) && (vga_hs === 1'b1);
    vs_rose = (vs_last === 1'b0) && (vga_vs === 1'b1);
    hs_last = vga_hs;
    vs_last = vga_vs;
    if (reset) begin
      hs_cnt = -1;
      line_cnt = -1;
    end else begin
      if (hs_rose) begin
        hs_cnt = 0;
      end else if (hs_cnt >= 0) begin
        hs_cnt++;
      end
      if (hs_cnt == `H_BACK) begin  // back porch over, line starts
        if (vs_rose) begin
          line_cnt = 0;
        end else if (line_cnt >= 0) begin
          line_cnt++;
        end
      end
    end
    pos_valid = (hs_cnt >= 0) && (line_cnt >= 0);
    scr_x = hs_cnt - `H_BACK;
    scr_y = line_cnt - `V_BACK;
    if (pos_valid) begin
      if (scr_x < 0 || scr_x >= `H_ACTIVE || scr_y < 0 || scr_y >= `V_ACTIVE) begin
        blank_or = blank_or | vga_r | vga_g | vga_b;
      end else if (scr_x < `WIN_X0 || scr_x >= `WIN_X0 + `IMG_W
                   || scr_y < `WIN_Y0 || scr_y >= `WIN_Y0 + `IMG_H) begin
        outside_or = outside_or | vga_r | vga_g | vga_b;
      end
    end
    -> sampled;
  end

  // gray rule, terms truncated, total clipped
  function automatic luma_t expected_gray(pix565_t p);
    int r8;
    int g8;
    int b8;
    int sum;
    r8 = p[15:11] * 8;  // widened to 8 bits
    g8 = p[10:5] * 4;
    b8 = p[4:0] * 8;
    sum = r8 / 4 + r8 / 32 + r8 / 64 + g8 / 2 + g8 / 16 + g8 / 32 + b8 / 8 + b8 / 32;
    if (sum > 255) begin
      sum = 255;
    end
    return luma_t'(sum);
  endfunction

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_chan(string what, vga_chan_t got, vga_chan_t exp);
    test_cnt++;
    if (got !== exp) begin
      fail_cnt++;
      $display("Error at %0t ns: %s read %0d, expected %0d", $time, what, got, exp);
    end else begin
      $display("ok    %s = %0d", what, got);
    end
  endtask

  task automatic check_sync(string what, logic got, logic exp);
    test_cnt++;
    if (got !== exp) begin
      fail_cnt++;
      $display("Error at %0t ns: %s read %b, expected %b", $time, what, got, exp);
    end else begin
      $display("ok    %s = %b", what, got);
    end
  endtask

  // shown is the pixel that must be on screen after the frame
  task automatic add_row(int x, int y, pix565_t pix, logic frz, pix565_t shown);
    row_x[n_rows] = x;
    row_y[n_rows] = y;
    row_pix[n_rows] = pix;
    row_frz[n_rows] = frz;
    row_exp[n_rows] = expected_gray(shown);
    n_rows++;
  endtask

  task automatic build_table();
    n_rows = 0;
    add_row(0, 0, 16'hffff, 1'b0, 16'hffff);  // white, clips at 255
    add_row(319, 0, 16'h0000, 1'b0, 16'h0000);
    add_row(5, 1, 16'hf800, 1'b0, 16'hf800);  // pure red
    add_row(160, 1, 16'h07e0, 1'b0, 16'h07e0);
    add_row(100, 2, 16'h8410, 1'b0, 16'h8410);  // mid gray
    add_row(318, 2, 16'h001f, 1'b0, 16'h001f);
    // frozen frame, old values must stay
    add_row(0, 0, 16'h0000, 1'b1, 16'hffff);
    add_row(319, 0, 16'hffff, 1'b1, 16'h0000);
    add_row(5, 1, 16'h07ff, 1'b1, 16'hf800);
    add_row(160, 1, 16'hf81f, 1'b1, 16'h07e0);
    add_row(100, 2, 16'h1234, 1'b1, 16'h8410);
    add_row(318, 2, 16'hffe0, 1'b1, 16'h001f);
  endtask

  task automatic step_cycles(int n);
    repeat (n) @(posedge clk_65mhz);
    #2;
  endtask

  task automatic load_frame(logic frz);
    for (int i = 0; i < FRAME_PIX; i++) begin
      rng_state = xorshift32(rng_state);
      frame_pix[i] = rng_state[15:0];  // filler
    end
    for (int r = 0; r < n_rows; r++) begin
      if (row_frz[r] == frz) begin
        frame_pix[row_y[r] * `IMG_W + row_x[r]] = row_pix[r];
      end
    end
  endtask

  task automatic send_byte(logic [7:0] b);
    cam_data = b;
    cam_href = 1'b1;
    cam_pclk = 1'b0;
    step_cycles(4);
    cam_pclk = 1'b1;  // data already stable for the whole low half
    step_cycles(4);
  endtask

  task automatic send_frame();
    cam_vsync = 1'b1;
    step_cycles(8);
    cam_vsync = 1'b0;
    step_cycles(16);
    for (int ln = 0; ln < 3; ln++) begin
      for (int px = 0; px < `IMG_W; px++) begin
        send_byte(frame_pix[ln * `IMG_W + px][15:8]);  // high byte first
        send_byte(frame_pix[ln * `IMG_W + px][7:0]);
      end
      cam_href = 1'b0;
      step_cycles(32);  // gap between lines
    end
  endtask

  task automatic wait_position(int x, int y);
    do begin
      @(sampled);
    end while (!(pos_valid && scr_x == x && scr_y == y));
  endtask

  task automatic check_rows(logic frz);
    string tag;
    for (int r = 0; r < n_rows; r++) begin
      if (row_frz[r] == frz) begin
        wait_position(`WIN_X0 + row_x[r], `WIN_Y0 + row_y[r]);
        tag = $sformatf("pixel (%0d,%0d) freeze %b", row_x[r], row_y[r], frz);
        check_chan({tag, " red"}, vga_r, row_exp[r][7:4]);
        check_chan({tag, " green"}, vga_g, row_exp[r][7:4]);
        check_chan({tag, " blue"}, vga_b, row_exp[r][7:4]);
      end
    end
  endtask

  // camera clock is half of the divider on, half off
  task automatic check_xclk_toggle();
    logic level;
    level = cam_xclk;
    do begin
      @(sampled);
    end while (cam_xclk === level);
    level = cam_xclk;
    repeat (`XCLK_DIV / 2 - 1) @(sampled);
    check_sync("cam_xclk holds between toggles", cam_xclk, level);
    @(sampled);
    check_sync("cam_xclk toggles after half the divider", cam_xclk, ~level);
  endtask

  task automatic check_hsync_timing();
    do begin
      @(sampled);
    end while (!hs_fell);
    repeat (`H_SYNC - 1) @(sampled);
    check_sync("vga_hs still low at end of pulse", vga_hs, 1'b0);
    @(sampled);
    check_sync("vga_hs high after 136 cycles", vga_hs, 1'b1);
    repeat (`H_TOTAL - `H_SYNC - 1) @(sampled);
    check_sync("vga_hs high one cycle before next fall", vga_hs, 1'b1);
    @(sampled);
    check_sync("vga_hs falls 1344 cycles later", vga_hs, 1'b0);
  endtask

  task automatic check_vsync_timing();
    do begin
      @(sampled);
    end while (!vs_fell);
    repeat (`V_SYNC * `H_TOTAL - 1) @(sampled);
    check_sync("vga_vs still low at end of 6 lines", vga_vs, 1'b0);
    @(sampled);
    check_sync("vga_vs high after 6 lines", vga_vs, 1'b1);
  endtask

  initial begin
    reset = 1'b1;
    cam_data = '0;
    cam_pclk = 1'b0;
    cam_vsync = 1'b0;
    cam_href = 1'b0;
    freeze = 1'b0;
    rng_state = 32'd74972;
    build_table();
    repeat (8) @(posedge clk_65mhz);
    #2;
    reset = 1'b0;

    // idle levels before any camera frame
    @(sampled);
    check_sync("vga_hs idle after reset", vga_hs, 1'b1);
    check_sync("vga_vs idle after reset", vga_vs, 1'b1);
    check_chan("red after reset", vga_r, '0);
    check_chan("green after reset", vga_g, '0);
    check_chan("blue after reset", vga_b, '0);
    check_sync("cam_xclk low after reset", cam_xclk, 1'b0);

    check_xclk_toggle();
    check_hsync_timing();
    check_vsync_timing();

    // phase 0 writes, phase 1 runs frozen
    for (int phase = 0; phase < 2; phase++) begin
      load_frame(phase == 1);
      step_cycles(1);
      freeze = (phase == 1);
      send_frame();
      step_cycles(16);  // last write lands
      check_rows(phase == 1);
    end

    check_chan("colors during blanking", blank_or, '0);
    check_chan("colors around the window", outside_or, '0);

    $display("tests %0d, passed %0d, failed %0d", test_cnt, test_cnt - fail_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* cam_view.f */
+incdir+design
design/camera_pkg.sv
design/video_pkg.sv
design/cam_pixel_if.sv
design/video_timing_if.sv
design/cam_capture.sv
design/luma_writer.sv
design/vga_timing.sv
design/display_window.sv
design/cam_view_top.sv
sim/cam_view_tb.sv

/* Bender.yml */
package:
  name: cam_view

sources:
  - include_dirs:
      - design
    files:
      - design/camera_pkg.sv
      - design/video_pkg.sv
      - design/cam_pixel_if.sv
      - design/video_timing_if.sv
      - design/cam_capture.sv
      - design/luma_writer.sv
      - design/vga_timing.sv
      - design/display_window.sv
      - design/cam_view_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/cam_view_tb.sv
